// File: files.f
hw/exu_pkg.sv
hw/exu_op_if.sv
hw/exu_issue_stage.sv
hw/exu_alu.sv
hw/exu_mul.sv
hw/exu_div.sv
hw/exu_writeback_stage.sv
hw/exu_top.sv
verification/exu_tb.sv

// File: hw/exu_alu.sv
`timescale 1ns/100ps
// Single-cycle integer ALU
module exu_alu #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
) (
    exu_op_if.dst            iss,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);
    localparam int SHW      = $clog2(XLEN);
    localparam bit HAS_WORD = (XLEN > 32);

    logic            word_mode;
    logic            do_sub;
    logic [XLEN-1:0] b_op;
    logic [XLEN:0]   sum;
    logic            lt_s;
    logic            lt_u;
    logic            slt_bit;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] r_sll;
    logic [XLEN-1:0] r_srl;
    logic [XLEN-1:0] r_sra;
    logic            sel_add;
    logic            sel_slt;
    logic [XLEN-1:0] raw;

    assign word_mode = HAS_WORD & iss.word;

    // --------------------
    // Shared adder
    // --------------------
    assign do_sub = iss.op inside {exu_pkg::OP_SUB, exu_pkg::OP_SLT, exu_pkg::OP_SLTU};
    assign b_op   = do_sub ? ~iss.src2 : iss.src2;
    assign sum    = {1'b0, iss.src1} + {1'b0, b_op} + {{XLEN{1'b0}}, do_sub};

    // No carry out means a borrow
    assign lt_u    = ~sum[XLEN];
    assign lt_s    = (iss.src1[XLEN-1] != iss.src2[XLEN-1]) ? iss.src1[XLEN-1] : sum[XLEN-1];
    assign slt_bit = (iss.op == exu_pkg::OP_SLTU) ? lt_u : lt_s;

    // --------------------
    // Shifter
    // --------------------
    assign shamt = word_mode ? SHW'(iss.src2[4:0]) : iss.src2[SHW-1:0];
    assign r_sll = iss.src1 << shamt;

    // Word shifts start from the extended low word
    assign r_srl = word_mode ? (XLEN'(iss.src1[31:0]) >> shamt) : (iss.src1 >> shamt);
    assign r_sra = word_mode ? ($signed(XLEN'($signed(iss.src1[31:0]))) >>> shamt)
                             : ($signed(iss.src1) >>> shamt);

    // One-hot result select
    assign sel_add = iss.op inside {exu_pkg::OP_ADD, exu_pkg::OP_SUB};
    assign sel_slt = iss.op inside {exu_pkg::OP_SLT, exu_pkg::OP_SLTU};

    assign raw = ({XLEN{sel_add}}                       & sum[XLEN-1:0])
               | ({XLEN{sel_slt}}                       & {{(XLEN-1){1'b0}}, slt_bit})
               | ({XLEN{iss.op == exu_pkg::OP_AND}}     & (iss.src1 & iss.src2))
               | ({XLEN{iss.op == exu_pkg::OP_OR}}      & (iss.src1 | iss.src2))
               | ({XLEN{iss.op == exu_pkg::OP_XOR}}     & (iss.src1 ^ iss.src2))
               | ({XLEN{iss.op == exu_pkg::OP_SLL}}     & r_sll)
               | ({XLEN{iss.op == exu_pkg::OP_SRL}}     & r_srl)
               | ({XLEN{iss.op == exu_pkg::OP_SRA}}     & r_sra);

    // Word results sign-extend from bit 31
    assign res_data  = word_mode ? XLEN'($signed(raw[31:0])) : raw;
    assign res_valid = iss.valid & ~exu_pkg::is_mul(iss.op) & ~exu_pkg::is_div(iss.op);
    assign res_tag   = iss.tag;

endmodule

// File: hw/exu_div.sv
`timescale 1ns/100ps
// Iterative restoring divider
module exu_div #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    exu_op_if.dst            iss,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);
    localparam int CNT_W    = $clog2(XLEN);
    localparam bit HAS_WORD = (XLEN > 32);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic             start;
    logic             word_mode;
    logic             sgn;
    logic [XLEN-1:0]  a_ext;
    logic [XLEN-1:0]  b_ext;
    logic [XLEN-1:0]  a_mag;
    logic [XLEN-1:0]  b_mag;
    logic [XLEN-1:0]  rem_r;
    logic [XLEN-1:0]  quo_r;
    logic [XLEN-1:0]  dvs_r;
    logic [XLEN:0]    trial;
    logic [XLEN:0]    diff;
    logic             neg_q;
    logic             neg_r;
    logic             zero_r;
    logic             word_r;
    exu_pkg::alu_op_e op_r;
    logic [XLEN-1:0]  q_fix;
    logic [XLEN-1:0]  r_fix;
    logic [XLEN-1:0]  res_raw;

    assign start     = (state == DIV_IDLE) & iss.valid & exu_pkg::is_div(iss.op);
    assign word_mode = HAS_WORD & iss.word;
    assign sgn       = iss.op inside {exu_pkg::OP_DIV, exu_pkg::OP_REM};

    // --------------------
    // Operand prep
    // --------------------
    assign a_ext = !word_mode ? iss.src1 :
                   sgn ? XLEN'($signed(iss.src1[31:0])) : XLEN'(iss.src1[31:0]);
    assign b_ext = !word_mode ? iss.src2 :
                   sgn ? XLEN'($signed(iss.src2[31:0])) : XLEN'(iss.src2[31:0]);
    assign a_mag = (sgn && a_ext[XLEN-1]) ? -a_ext : a_ext;
    assign b_mag = (sgn && b_ext[XLEN-1]) ? -b_ext : b_ext;

    // One restoring step
    assign trial = {rem_r, quo_r[XLEN-1]};
    assign diff  = trial - {1'b0, dvs_r};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else if (flush) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    cnt <= '0;
                    if (start)
                        state <= DIV_RUN;
                end
                DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(XLEN - 1))
                        state <= DIV_DONE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_r  <= '0;
            quo_r  <= a_mag;
            dvs_r  <= b_mag;
            op_r   <= iss.op;
            word_r <= word_mode;
            res_tag <= iss.tag;
            neg_q  <= sgn & (a_ext[XLEN-1] ^ b_ext[XLEN-1]);
            neg_r  <= sgn & a_ext[XLEN-1];
            zero_r <= (b_ext == '0);
        end else if (state == DIV_RUN) begin
            // Keep the shifted remainder when the trial goes negative
            rem_r <= diff[XLEN] ? trial[XLEN-1:0] : diff[XLEN-1:0];
            quo_r <= {quo_r[XLEN-2:0], ~diff[XLEN]};
        end
    end

    // --------------------
    // Sign fix and select
    // --------------------
    // The negated magnitude of the most negative dividend wraps back to itself
    assign q_fix   = zero_r ? '1 : (neg_q ? -quo_r : quo_r);
    assign r_fix   = neg_r ? -rem_r : rem_r;
    assign res_raw = (op_r inside {exu_pkg::OP_REM, exu_pkg::OP_REMU}) ? r_fix : q_fix;

    assign res_data  = word_r ? XLEN'($signed(res_raw[31:0])) : res_raw;
    assign res_valid = (state == DIV_DONE);

endmodule

// File: hw/exu_issue_stage.sv
`timescale 1ns/100ps
// Execute unit issue stage
module exu_issue_stage #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    input  exu_pkg::alu_op_e in_op,
    input  logic             in_word,
    input  logic [XLEN-1:0]  in_src1,
    input  logic [XLEN-1:0]  in_src2,
    input  logic [TAG_W-1:0] in_tag,
    exu_op_if.src            iss,
    input  logic             long_done,
    output logic             busy
);
    logic long_op;

    // Multi-cycle classes hold off the requester
    assign long_op = exu_pkg::is_mul(in_op) | exu_pkg::is_div(in_op);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss.valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            iss.valid <= in_valid & ~flush;
            if (flush || long_done)
                busy <= 1'b0;
            else if (in_valid && long_op)
                busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        iss.op   <= in_op;
        iss.word <= in_word;
        iss.src1 <= in_src1;
        iss.src2 <= in_src2;
        iss.tag  <= in_tag;
    end

endmodule

// File: hw/exu_mul.sv
`timescale 1ns/100ps
// Two-stage pipelined multiplier
module exu_mul #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    exu_op_if.dst            iss,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);
    localparam bit HAS_WORD = (XLEN > 32);

    logic                     a_sgn;
    logic                     b_sgn;
    logic                     s1_valid;
    exu_pkg::alu_op_e         s1_op;
    logic                     s1_word;
    logic [TAG_W-1:0]         s1_tag;
    logic signed [XLEN:0]     s1_a;
    logic signed [XLEN:0]     s1_b;
    logic signed [2*XLEN+1:0] prod;
    logic [XLEN-1:0]          prod_sel;

    // Sign mode per operand
    assign a_sgn = iss.op inside {exu_pkg::OP_MUL, exu_pkg::OP_MULH, exu_pkg::OP_MULHSU};
    assign b_sgn = iss.op inside {exu_pkg::OP_MUL, exu_pkg::OP_MULH};

    // --------------------
    // Stage 1
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= iss.valid & exu_pkg::is_mul(iss.op) & ~flush;
    end

    always_ff @(posedge clk) begin
        s1_op   <= iss.op;
        s1_word <= HAS_WORD & iss.word;
        s1_tag  <= iss.tag;
        s1_a    <= {a_sgn & iss.src1[XLEN-1], iss.src1};
        s1_b    <= {b_sgn & iss.src2[XLEN-1], iss.src2};
    end

    // --------------------
    // Stage 2
    // --------------------
    assign prod     = s1_a * s1_b;
    assign prod_sel = (s1_op == exu_pkg::OP_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= s1_valid & ~flush;
    end

    always_ff @(posedge clk) begin
        res_data <= s1_word ? XLEN'($signed(prod_sel[31:0])) : prod_sel;
        res_tag  <= s1_tag;
    end

endmodule

// File: hw/exu_op_if.sv
`timescale 1ns/100ps
// Issued operation bus
interface exu_op_if #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
);
    logic                valid;
    exu_pkg::alu_op_e    op;
    logic                word;
    logic [XLEN-1:0]     src1;
    logic [XLEN-1:0]     src2;
    logic [TAG_W-1:0]    tag;

    // Issue stage side
    modport src (
        output valid, op, word, src1, src2, tag
    );

    // Function unit side
    modport dst (
        input valid, op, word, src1, src2, tag
    );

endinterface

// File: hw/exu_pkg.sv
// Execute unit shared types
package exu_pkg;

    // --------------------
    // Operation codes
    // --------------------
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } alu_op_e;

    // --------------------
    // Opcode classes
    // --------------------
    function automatic logic is_mul(alu_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    function automatic logic is_div(alu_op_e op);
        return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

endpackage

// File: hw/exu_top.sv
`timescale 1ns/100ps
// Integer execute unit
module exu_top #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    input  exu_pkg::alu_op_e in_op,
    input  logic             in_word,
    input  logic [XLEN-1:0]  in_src1,
    input  logic [XLEN-1:0]  in_src2,
    input  logic [TAG_W-1:0] in_tag,
    output logic             busy,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_data,
    output logic [TAG_W-1:0] out_tag
);
    logic             alu_valid;
    logic [XLEN-1:0]  alu_data;
    logic [TAG_W-1:0] alu_tag;
    logic             mul_valid;
    logic [XLEN-1:0]  mul_data;
    logic [TAG_W-1:0] mul_tag;
    logic             div_valid;
    logic [XLEN-1:0]  div_data;
    logic [TAG_W-1:0] div_tag;
    logic             long_done;

    exu_op_if #(.XLEN(XLEN), .TAG_W(TAG_W)) iss ();

    exu_issue_stage #(.XLEN(XLEN), .TAG_W(TAG_W)) u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_word   (in_word),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_tag    (in_tag),
        .iss       (iss.src),
        .long_done (long_done),
        .busy      (busy)
    );

    // --------------------
    // Function units
    // --------------------
    exu_alu #(.XLEN(XLEN), .TAG_W(TAG_W)) u_alu (
        .iss       (iss.dst),
        .res_valid (alu_valid),
        .res_data  (alu_data),
        .res_tag   (alu_tag)
    );

    exu_mul #(.XLEN(XLEN), .TAG_W(TAG_W)) u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .iss       (iss.dst),
        .res_valid (mul_valid),
        .res_data  (mul_data),
        .res_tag   (mul_tag)
    );

    exu_div #(.XLEN(XLEN), .TAG_W(TAG_W)) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .iss       (iss.dst),
        .res_valid (div_valid),
        .res_data  (div_data),
        .res_tag   (div_tag)
    );

    exu_writeback_stage #(.XLEN(XLEN), .TAG_W(TAG_W)) u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .alu_valid (alu_valid),
        .alu_data  (alu_data),
        .alu_tag   (alu_tag),
        .mul_valid (mul_valid),
        .mul_data  (mul_data),
        .mul_tag   (mul_tag),
        .div_valid (div_valid),
        .div_data  (div_data),
        .div_tag   (div_tag),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_tag   (out_tag),
        .long_done (long_done)
    );

endmodule

// File: hw/exu_writeback_stage.sv
`timescale 1ns/100ps
// Execute unit writeback stage
module exu_writeback_stage #(
    parameter int XLEN  = 64,
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             alu_valid,
    input  logic [XLEN-1:0]  alu_data,
    input  logic [TAG_W-1:0] alu_tag,
    input  logic             mul_valid,
    input  logic [XLEN-1:0]  mul_data,
    input  logic [TAG_W-1:0] mul_tag,
    input  logic             div_valid,
    input  logic [XLEN-1:0]  div_data,
    input  logic [TAG_W-1:0] div_tag,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_data,
    output logic [TAG_W-1:0] out_tag,
    output logic             long_done
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            long_done <= 1'b0;
        end else begin
            out_valid <= (alu_valid | mul_valid | div_valid) & ~flush;
            long_done <= (mul_valid | div_valid) & ~flush;
        end
    end

    // At most one unit reports per cycle
    always_ff @(posedge clk) begin
        if (div_valid) begin
            out_data <= div_data;
            out_tag  <= div_tag;
        end else if (mul_valid) begin
            out_data <= mul_data;
            out_tag  <= mul_tag;
        end else begin
            out_data <= alu_data;
            out_tag  <= alu_tag;
        end
    end

endmodule

// File: verification/exu_tb.sv
`timescale 1ns/100ps
// Execute unit testbench
module exu_tb;

    localparam int XLEN      = 64;
    localparam int TAG_W     = 4;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 200;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             in_valid;
    exu_pkg::alu_op_e in_op;
    logic             in_word;
    logic [XLEN-1:0]  in_src1;
    logic [XLEN-1:0]  in_src2;
    logic [TAG_W-1:0] in_tag;
    logic             busy;
    logic             out_valid;
    logic [XLEN-1:0]  out_data;
    logic [TAG_W-1:0] out_tag;

    // Stimulus table
    exu_pkg::alu_op_e tbl_op  [MAX_CASES];
    logic             tbl_word[MAX_CASES];
    logic [XLEN-1:0]  tbl_a   [MAX_CASES];
    logic [XLEN-1:0]  tbl_b   [MAX_CASES];
    logic [XLEN-1:0]  tbl_exp [MAX_CASES];
    int               n_cases;
    int               first_div;
    int               pass_count;
    int               fail_count;

    exu_top #(.XLEN(XLEN), .TAG_W(TAG_W)) u_exu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_word   (in_word),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_tag    (in_tag),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_tag   (out_tag)
    );

    always #2 clk = ~clk;

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // 0 for ALU, 1 for multiply, 2 for divide
    function automatic int unit_of(input exu_pkg::alu_op_e op);
        case (op)
            exu_pkg::OP_MUL, exu_pkg::OP_MULH,
            exu_pkg::OP_MULHSU, exu_pkg::OP_MULHU: return 1;
            exu_pkg::OP_DIV, exu_pkg::OP_DIVU,
            exu_pkg::OP_REM, exu_pkg::OP_REMU:     return 2;
            default:                               return 0;
        endcase
    endfunction

    function automatic logic [63:0] alu_ref(input exu_pkg::alu_op_e op, input logic w,
                                            input logic [63:0] a, input logic [63:0] b);
        logic [5:0]  amt;
        logic [63:0] za;
        logic [63:0] sa;
        logic [63:0] r;
        amt = w ? {1'b0, b[4:0]} : b[5:0];
        za  = w ? {32'b0, a[31:0]} : a;
        sa  = w ? sext32(a[31:0]) : a;
        case (op)
            exu_pkg::OP_ADD:  r = a + b;
            exu_pkg::OP_SUB:  r = a - b;
            exu_pkg::OP_SLT:  r = {63'b0, $signed(a) < $signed(b)};
            exu_pkg::OP_SLTU: r = {63'b0, a < b};
            exu_pkg::OP_AND:  r = a & b;
            exu_pkg::OP_OR:   r = a | b;
            exu_pkg::OP_XOR:  r = a ^ b;
            exu_pkg::OP_SLL:  r = a << amt;
            exu_pkg::OP_SRL:  r = za >> amt;
            exu_pkg::OP_SRA:  r = $signed(sa) >>> amt;
            default:          r = '0;
        endcase
        return w ? sext32(r[31:0]) : r;
    endfunction

    function automatic logic [63:0] mul_ref(input exu_pkg::alu_op_e op, input logic w,
                                            input logic [63:0] a, input logic [63:0] b);
        logic         a_signed;
        logic         b_signed;
        logic [127:0] p;
        logic [63:0]  r;
        a_signed = (op != exu_pkg::OP_MULHU);
        b_signed = (op == exu_pkg::OP_MUL) || (op == exu_pkg::OP_MULH);
        p = {{64{a_signed & a[63]}}, a} * {{64{b_signed & b[63]}}, b};
        r = (op == exu_pkg::OP_MUL) ? p[63:0] : p[127:64];
        return w ? sext32(r[31:0]) : r;
    endfunction

    function automatic logic [63:0] div_ref(input exu_pkg::alu_op_e op, input logic w,
                                            input logic [63:0] a, input logic [63:0] b);
        logic        sgn;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] q;
        logic [63:0] r;
        sgn = (op == exu_pkg::OP_DIV) || (op == exu_pkg::OP_REM);
        x = !w ? a : (sgn ? sext32(a[31:0]) : {32'b0, a[31:0]});
        y = !w ? b : (sgn ? sext32(b[31:0]) : {32'b0, b[31:0]});
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && x == 64'h8000_0000_0000_0000 && y == '1) begin
            q = x;
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        q = (op == exu_pkg::OP_REM || op == exu_pkg::OP_REMU) ? r : q;
        return w ? sext32(q[31:0]) : q;
    endfunction

    function automatic logic [63:0] ref_result(input exu_pkg::alu_op_e op, input logic w,
                                               input logic [63:0] a, input logic [63:0] b);
        case (unit_of(op))
            1:       return mul_ref(op, w, a, b);
            2:       return div_ref(op, w, a, b);
            default: return alu_ref(op, w, a, b);
        endcase
    endfunction

    // --------------------
    // Table and drive helpers
    // --------------------
    task automatic add_case(input exu_pkg::alu_op_e op, input logic w,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        tbl_op[n_cases]   = op;
        tbl_word[n_cases] = w;
        tbl_a[n_cases]    = a;
        tbl_b[n_cases]    = b;
        tbl_exp[n_cases]  = ref_result(op, w, a, b);
        n_cases++;
    endtask

    task automatic drive(input int i, input logic [TAG_W-1:0] tag);
        in_valid = 1'b1;
        in_op    = tbl_op[i];
        in_word  = tbl_word[i];
        in_src1  = tbl_a[i];
        in_src2  = tbl_b[i];
        in_tag   = tag;
    endtask

    task automatic check_result(input int i, input logic [TAG_W-1:0] tag, inout logic ok);
        if (out_data !== tbl_exp[i]) begin
            $display("FAIL out_data case %0d: got %h expected %h", i, out_data, tbl_exp[i]);
            ok = 1'b0;
        end
        if (out_tag !== tag) begin
            $display("FAIL out_tag case %0d: got %h expected %h", i, out_tag, tag);
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string label, input logic ok);
        $display("test %s: %s", label, ok ? "ok" : "bad");
        if (ok)
            pass_count++;
        else
            fail_count++;
    endtask

    // --------------------
    // Test sequences
    // --------------------
    task automatic run_case(input int i);
        int               lat;
        int               unit;
        logic             ok;
        logic             busy_bad;
        logic             busy_got;
        logic [TAG_W-1:0] tag;
        unit     = unit_of(tbl_op[i]);
        tag      = TAG_W'(i);
        ok       = 1'b1;
        busy_bad = 1'b0;
        busy_got = 1'b0;
        lat      = 0;
        @(negedge clk);
        drive(i, tag);
        while (lat == 0 || (out_valid !== 1'b1 && lat < TIMEOUT)) begin
            @(negedge clk);
            in_valid = 1'b0;
            lat++;
            // Busy holds from cycle 1 through the out_valid cycle for long ops
            if (!busy_bad && busy !== (unit != 0)) begin
                busy_bad = 1'b1;
                busy_got = busy;
            end
        end
        if (out_valid !== 1'b1) begin
            $display("case %0d: no out_valid within %0d cycles", i, TIMEOUT);
            ok = 1'b0;
        end else begin
            check_result(i, tag, ok);
            // Fixed latency per unit
            if (lat != ((unit == 2) ? XLEN + 3 : (unit == 1) ? 4 : 2)) begin
                $display("case %0d: out_valid came after %0d cycles", i, lat);
                ok = 1'b0;
            end
        end
        if (busy_bad) begin
            $display("FAIL busy case %0d: got %h expected %h", i, busy_got, unit != 0);
            ok = 1'b0;
        end
        lat = 0;
        while (busy !== 1'b0 && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        if (busy !== 1'b0) begin
            $display("case %0d: busy did not fall after the result", i);
            ok = 1'b0;
        end
        finish_test($sformatf("%0d %s word=%0d", i, tbl_op[i].name(), tbl_word[i]), ok);
    endtask

    // Two ALU operations on consecutive cycles
    task automatic pair_case(input int i, input int j);
        int   t;
        logic ok;
        ok = 1'b1;
        t  = 0;
        @(negedge clk);
        drive(i, TAG_W'(i));
        @(negedge clk);
        drive(j, TAG_W'(j));
        @(negedge clk);
        in_valid = 1'b0;
        while (out_valid !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (out_valid !== 1'b1) begin
            $display("back-to-back: no out_valid within %0d cycles", TIMEOUT);
            ok = 1'b0;
        end else begin
            check_result(i, TAG_W'(i), ok);
            @(negedge clk);
            if (out_valid !== 1'b1) begin
                $display("back-to-back: second result did not follow on the next cycle");
                ok = 1'b0;
            end else begin
                check_result(j, TAG_W'(j), ok);
            end
        end
        finish_test("back-to-back ALU", ok);
    endtask

    task automatic flush_case(input int i);
        int   t;
        logic ok;
        logic seen;
        ok   = 1'b1;
        seen = 1'b0;
        @(negedge clk);
        drive(i, TAG_W'(i));
        @(negedge clk);
        in_valid = 1'b0;
        repeat (3) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // Busy drops on the edge that takes the flush
        if (busy !== 1'b0) begin
            $display("FAIL busy after flush: got %h expected %h", busy, 1'b0);
            ok = 1'b0;
        end
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk);
            if (out_valid !== 1'b0)
                seen = 1'b1;
        end
        if (seen) begin
            $display("flush: out_valid appeared for a killed divide");
            ok = 1'b0;
        end
        finish_test("flush during divide", ok);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic [XLEN-1:0] amt[4];
        int              k;
        int              w;
        int              i;
        clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_op      = exu_pkg::OP_ADD;
        in_word    = 1'b0;
        in_src1    = '0;
        in_src2    = '0;
        in_tag     = '0;
        n_cases    = 0;
        pass_count = 0;
        fail_count = 0;
        amt        = '{64'd0, 64'd31, 64'd32, 64'd63};

        // Adder, compare and logic edges
        add_case(exu_pkg::OP_ADD,  1'b0, 64'h7fff_ffff_ffff_ffff, 64'h1);
        add_case(exu_pkg::OP_ADD,  1'b0, '1, 64'h1);
        add_case(exu_pkg::OP_SUB,  1'b0, 64'h0, 64'h1);
        add_case(exu_pkg::OP_SUB,  1'b0, 64'h8000_0000_0000_0000, 64'h1);
        add_case(exu_pkg::OP_SLT,  1'b0, 64'h8000_0000_0000_0000, 64'h1);
        add_case(exu_pkg::OP_SLT,  1'b0, 64'h1, '1);
        add_case(exu_pkg::OP_SLTU, 1'b0, 64'h1, '1);
        add_case(exu_pkg::OP_SLTU, 1'b0, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff);
        add_case(exu_pkg::OP_AND,  1'b0, 64'hf0f0_f0f0_1234_5678, 64'hff00_ff00_ffff_0000);
        add_case(exu_pkg::OP_OR,   1'b0, 64'hf0f0_f0f0_1234_5678, 64'h0f00_00ff_0000_8001);
        add_case(exu_pkg::OP_XOR,  1'b0, 64'haaaa_5555_aaaa_5555, 64'hffff_0000_0000_ffff);
        add_case(exu_pkg::OP_ADD,  1'b1, 64'h0000_0000_7fff_ffff, 64'h1);
        add_case(exu_pkg::OP_SUB,  1'b1, 64'h1234_5678_0000_0000, 64'h1);

        // Shift amounts in both modes
        for (w = 0; w < 2; w++) begin
            for (k = 0; k < 4; k++) begin
                add_case(exu_pkg::OP_SLL, w != 0, 64'hc000_0001_8765_4321, amt[k]);
                add_case(exu_pkg::OP_SRL, w != 0, 64'hc000_0001_8765_4321, amt[k]);
                add_case(exu_pkg::OP_SRA, w != 0, 64'hc000_0001_8765_4321, amt[k]);
            end
        end

        add_case(exu_pkg::OP_MUL,    1'b0, 64'hffff_ffff_ffff_fffd, 64'h7);
        add_case(exu_pkg::OP_MULH,   1'b0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        add_case(exu_pkg::OP_MULH,   1'b0, 64'hffff_ffff_ffff_fffd, 64'h7);
        add_case(exu_pkg::OP_MULHSU, 1'b0, 64'hffff_ffff_ffff_fffe, '1);
        add_case(exu_pkg::OP_MULHU,  1'b0, '1, '1);
        add_case(exu_pkg::OP_MUL,    1'b1, 64'h1234_0000_0001_0000, 64'h8000);

        first_div = n_cases;
        add_case(exu_pkg::OP_DIV,  1'b0, 64'hffff_ffff_ffff_fff9, 64'h2);
        add_case(exu_pkg::OP_DIVU, 1'b0, 64'hffff_ffff_ffff_fff9, 64'h2);
        add_case(exu_pkg::OP_REM,  1'b0, 64'hffff_ffff_ffff_fff9, 64'h2);
        add_case(exu_pkg::OP_REMU, 1'b0, 64'hffff_ffff_ffff_fffa, 64'h5);
        add_case(exu_pkg::OP_DIV,  1'b0, 64'h1234_5678_9abc_def0, 64'h0);
        add_case(exu_pkg::OP_DIVU, 1'b0, 64'h1234_5678_9abc_def0, 64'h0);
        add_case(exu_pkg::OP_REM,  1'b0, 64'hffff_ffff_ffff_fff9, 64'h0);
        add_case(exu_pkg::OP_REMU, 1'b0, 64'h1234_5678_9abc_def0, 64'h0);
        add_case(exu_pkg::OP_DIV,  1'b0, 64'h8000_0000_0000_0000, '1);
        add_case(exu_pkg::OP_REM,  1'b0, 64'h8000_0000_0000_0000, '1);
        add_case(exu_pkg::OP_DIV,  1'b1, 64'hdead_beef_8000_0000, 64'h0000_0000_ffff_ffff);
        add_case(exu_pkg::OP_REM,  1'b1, 64'hdead_beef_8000_0000, 64'h0000_0000_ffff_ffff);
        add_case(exu_pkg::OP_DIV,  1'b1, 64'hdead_beef_8000_0005, 64'h1234_5678_0000_0000);
        add_case(exu_pkg::OP_DIVU, 1'b1, 64'h0000_0001_ffff_fff9, 64'h5);
        add_case(exu_pkg::OP_REMU, 1'b1, 64'h0000_0001_ffff_fff9, 64'h5);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; i < n_cases; i++)
            run_case(i);
        pair_case(0, 2);
        flush_case(first_div);
        run_case(0);

        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
